//--- tb/friscv_golden.hex
// Words 0 to 31 hold the program at byte address 4 times the index
// Then expected stores as address and data per line until a pair of all ones
00500093 FFD00113  // addi x1,x0,5       addi x2,x0,-3
002081B3 40208233  // add x3,x1,x2       sub x4,x1,x2
10302023 10402223  // sw x3,0x100(x0)    sw x4,0x104(x0)
123452B7 00001317  // lui x5,0x12345     auipc x6,1
10502423 10602623  // sw x5,0x108(x0)    sw x6,0x10c(x0)
40115393 00112433  // srai x7,x2,1       slt x8,x2,x1
10702823 10802A23  // sw x7,0x110(x0)    sw x8,0x114(x0)
00208463 00209463  // beq x1,x2,+8       bne x1,x2,+8
1E102823 008004EF  // sw x1,0x1f0(x0)    jal x9,+8
1E102A23 10902C23  // sw x1,0x1f4(x0)    sw x9,0x118(x0)
05C00513 001505E7  // addi x10,x0,0x5c   jalr x11,1(x10)
1E102C23 10B02E23  // sw x1,0x1f8(x0)    sw x11,0x11c(x0)
00114463 1E102E23  // blt x2,x1,+8       sw x1,0x1fc(x0)
0020F463 FFF2C613  // bgeu x1,x2,+8      xori x12,x5,-1
12C02023 001096B3  // sw x12,0x120(x0)   sll x13,x1,x1
12D02223 00000073  // sw x13,0x124(x0)   ecall
00000100 00000002  // 5 + -3
00000104 00000008  // 5 - -3
00000108 12345000  // lui
0000010C 0000101C  // auipc at 0x1c
00000110 FFFFFFFE  // -3 >>> 1
00000114 00000001  // -3 < 5 signed
00000118 00000048  // jal link
0000011C 00000058  // jalr link
00000120 EDCBAFFF  // 0x12345000 ^ -1
00000124 000000A0  // 5 << 5
FFFFFFFF FFFFFFFF

//--- src.f
common/friscv_pkg.sv
src/friscv_registers.sv
control/friscv_decoder.sv
control/friscv_control.sv
processing/friscv_alu.sv
processing/friscv_memfy.sv
src/friscv_rv32i_core.sv
tb/friscv_tb.sv

//--- Bender.yml
package:
  name: friscv_rv32i

sources:
  - common/friscv_pkg.sv
  - src/friscv_registers.sv
  - control/friscv_decoder.sv
  - control/friscv_control.sv
  - processing/friscv_alu.sv
  - processing/friscv_memfy.sv
  - src/friscv_rv32i_core.sv
  - target: simulation
    files:
      - tb/friscv_tb.sv

//--- tb/friscv_tb.sv
// Testbench for the RV32I core with program and expected stores from tb/friscv_golden.hex
// Run from the project root so that the data file is found
module friscv_tb import friscv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_WORDS = 32;
    localparam int GOLD_BASE  = 32;
    localparam int TIMEOUT    = 2000;

    logic                aclk;
    logic                rst;
    logic [STATUS_W-1:0] status;
    logic                imem_arvalid;
    logic                imem_arready;
    logic [XLEN-1:0]     imem_araddr;
    logic                imem_rvalid;
    logic                imem_rready;
    logic [ILEN-1:0]     imem_rdata;
    logic                dmem_awvalid;
    logic                dmem_awready;
    logic [XLEN-1:0]     dmem_awaddr;
    logic                dmem_wvalid;
    logic                dmem_wready;
    logic [XLEN-1:0]     dmem_wdata;
    logic [3:0]          dmem_wstrb;
    logic                dmem_bvalid;
    logic                dmem_bready;

    // Program words followed by the expected store pairs
    logic [31:0] mem [64];
    logic [15:0] lfsr;
    logic        throttle;
    int          st_idx;

    // Bus model state
    logic            rd_pend;
    logic [XLEN-1:0] rd_addr;
    logic            aw_got;
    logic            w_got;
    logic            b_pend;
    logic [XLEN-1:0] aw_addr;
    logic [XLEN-1:0] w_data;

    // DUT outputs seen at the previous falling edge
    logic            arvalid_q;
    logic [XLEN-1:0] araddr_q;
    logic            rready_q;
    logic            awvalid_q;
    logic [XLEN-1:0] awaddr_q;
    logic            wvalid_q;
    logic [XLEN-1:0] wdata_q;
    logic            bready_q;

    friscv_rv32i_core u_friscv_rv32i_core (.*);

    initial begin
        aclk = 1'b0;
        forever begin
            #50 aclk = ~aclk;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic stop_fail(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            stop_fail($sformatf("FAIL at %0t ns: %s, got %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    // 16 bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Random only while back-pressure is on
    task automatic pick_ready(output logic r);
        if (throttle) begin
            r    = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end else begin
            r = 1'b1;
        end
    endtask

    task automatic match_store(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
        if (mem[GOLD_BASE + 2*st_idx] === 32'hFFFF_FFFF) begin
            stop_fail($sformatf("Unexpected store to %h after the last expected store", addr));
        end
        check(addr, mem[GOLD_BASE + 2*st_idx], "store address");
        check(data, mem[GOLD_BASE + 2*st_idx + 1], "store data");
        st_idx <= st_idx + 1;
    endtask

    task automatic wait_cycle(inout int n, input string what);
        @(negedge aclk);
        n++;
        if (n > TIMEOUT) begin
            stop_fail($sformatf("Timed out after %0d cycles waiting for %s", TIMEOUT, what));
        end
    endtask

    ////////////////////
    // Memory models
    ////////////////////

    always @(negedge aclk) begin : bus_models
        logic hs_ar;
        logic hs_r;
        logic hs_aw;
        logic hs_w;
        logic hs_b;
        logic ok;
        if (rst) begin
            rd_pend = 1'b0;
            aw_got  = 1'b0;
            w_got   = 1'b0;
            b_pend  = 1'b0;
            st_idx       <= 0;
            imem_arready <= 1'b0;
            imem_rvalid  <= 1'b0;
            dmem_awready <= 1'b0;
            dmem_wready  <= 1'b0;
            dmem_bvalid  <= 1'b0;
        end else begin
            // Handshakes of the last rising edge
            hs_ar = arvalid_q && imem_arready;
            hs_r  = imem_rvalid && rready_q;
            hs_aw = awvalid_q && dmem_awready;
            hs_w  = wvalid_q && dmem_wready;
            hs_b  = dmem_bvalid && bready_q;
            if (arvalid_q && !imem_arready) begin
                check(imem_arvalid, 1'b1, "arvalid dropped before arready");
                check(imem_araddr, araddr_q, "araddr changed while arvalid high");
            end
            if (awvalid_q && !dmem_awready) begin
                check(dmem_awvalid, 1'b1, "awvalid dropped before awready");
                check(dmem_awaddr, awaddr_q, "awaddr changed while awvalid high");
            end
            if (wvalid_q && !dmem_wready) begin
                check(dmem_wvalid, 1'b1, "wvalid dropped before wready");
                check(dmem_wdata, wdata_q, "wdata changed while wvalid high");
            end
            if (dmem_wvalid) begin
                check(dmem_wstrb, 4'hF, "wstrb of a word store");
            end
            if (hs_r) rd_pend = 1'b0;
            if (hs_ar) begin
                if (araddr_q >= 4*PROG_WORDS) begin
                    stop_fail($sformatf("Fetch from %h outside the program", araddr_q));
                end
                rd_pend = 1'b1;
                rd_addr = araddr_q;
            end
            // rready is high from the AR acceptance until the R acceptance
            check(imem_rready, rd_pend, "rready outside a pending read");
            if (hs_aw) begin
                aw_got  = 1'b1;
                aw_addr = awaddr_q;
            end
            if (hs_w) begin
                w_got  = 1'b1;
                w_data = wdata_q;
            end
            if (hs_b) b_pend = 1'b0;
            if (aw_got && w_got) begin
                match_store(aw_addr, w_data);
                aw_got = 1'b0;
                w_got  = 1'b0;
                b_pend = 1'b1;
            end
            // bready is high from the last of AW and W until the B acceptance
            check(dmem_bready, b_pend, "bready outside a pending write response");
            pick_ready(ok);
            imem_arready <= ok;
            if (rd_pend && !imem_rvalid) begin
                pick_ready(ok);
                imem_rvalid <= ok;
                imem_rdata  <= mem[rd_addr[6:2]];
            end else if (!rd_pend) begin
                imem_rvalid <= 1'b0;
            end
            pick_ready(ok);
            dmem_awready <= ok;
            pick_ready(ok);
            dmem_wready <= ok;
            if (b_pend && !dmem_bvalid) begin
                pick_ready(ok);
                dmem_bvalid <= ok;
            end else if (!b_pend) begin
                dmem_bvalid <= 1'b0;
            end
        end
        arvalid_q = imem_arvalid;
        araddr_q  = imem_araddr;
        rready_q  = imem_rready;
        awvalid_q = dmem_awvalid;
        awaddr_q  = dmem_awaddr;
        wvalid_q  = dmem_wvalid;
        wdata_q   = dmem_wdata;
        bready_q  = dmem_bready;
    end

    ////////////////////
    // Test sequence
    ////////////////////

    task automatic apply_reset(input logic bp);
        @(negedge aclk);
        rst      <= 1'b1;
        throttle <= bp;
        repeat (4) @(negedge aclk);
        rst <= 1'b0;
    endtask

    task automatic run_program(input logic bp, input int trap_bit);
        int n;
        apply_reset(bp);
        check(status, '0, "status after reset");
        check(imem_arvalid, 1'b0, "arvalid during reset");
        n = 0;
        while (!imem_arvalid) begin
            check(dmem_awvalid || dmem_wvalid, 1'b0, "dmem valid before the first store");
            wait_cycle(n, "the first fetch");
        end
        check(n, 1, "cycles from reset to the first fetch");
        check(imem_araddr, BOOT_ADDR, "first fetch address");
        n = 0;
        while (mem[GOLD_BASE + 2*st_idx] !== 32'hFFFF_FFFF) begin
            wait_cycle(n, "the expected stores");
        end
        n = 0;
        while (!status[trap_bit]) begin
            wait_cycle(n, "the trap status bit");
        end
        // Trap is sticky and fetching stays halted
        repeat (50) begin
            @(negedge aclk);
            check(status, 32'(1) << trap_bit, "status after the trap");
            check(imem_arvalid, 1'b0, "arvalid after the trap");
        end
    endtask

    initial begin
        rst          = 1'b1;
        throttle     = 1'b0;
        lfsr         = 16'd42;
        imem_arready = 1'b0;
        imem_rvalid  = 1'b0;
        imem_rdata   = '0;
        dmem_awready = 1'b0;
        dmem_wready  = 1'b0;
        dmem_bvalid  = 1'b0;
        $readmemh("tb/friscv_golden.hex", mem);
        if (mem[GOLD_BASE] === 'x) begin
            stop_fail("Golden file tb/friscv_golden.hex did not load");
        end
        run_program(1'b0, ST_ECALL);
        run_program(1'b1, ST_ECALL);
        // Final ECALL becomes lw x0,0(x0) which lies outside the subset
        mem[PROG_WORDS-1] = 32'h0000_2003;
        run_program(1'b1, ST_ILLEGAL);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- src/friscv_rv32i_core.sv
// RV32I core without caches, CSRs or loads, one instruction at a time
// A trap halts fetching until rst, the cause stays on status
module friscv_rv32i_core import friscv_pkg::*; (
    input  logic                aclk,
    input  logic                rst,
    output logic [STATUS_W-1:0] status,
    // Instruction read channel
    output logic                imem_arvalid,
    input  logic                imem_arready,
    output logic [XLEN-1:0]     imem_araddr,
    input  logic                imem_rvalid,
    output logic                imem_rready,
    input  logic [ILEN-1:0]     imem_rdata,
    // Data write channel
    output logic                dmem_awvalid,
    input  logic                dmem_awready,
    output logic [XLEN-1:0]     dmem_awaddr,
    output logic                dmem_wvalid,
    input  logic                dmem_wready,
    output logic [XLEN-1:0]     dmem_wdata,
    output logic [3:0]          dmem_wstrb,
    input  logic                dmem_bvalid,
    output logic                dmem_bready
);

    ////////////////////
    // Internal wires
    ////////////////////

    logic [ILEN-1:0]       instr;
    opcode_t               opcode;
    logic                  illegal;
    logic                  is_ecall;
    logic                  is_ebreak;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       imm;
    alu_op_t               alu_op;
    logic                  use_imm;
    br_op_t                br_op;

    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    logic                  rd_wr;
    logic [XLEN-1:0]       rd_wdata;

    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       alu_result;
    logic                  branch_taken;
    logic [XLEN-1:0]       next_pc;
    logic [XLEN-1:0]       link_val;

    logic                  st_start;
    logic [XLEN-1:0]       st_addr;
    logic [XLEN-1:0]       st_data;
    logic                  st_done;

    ////////////////////
    // Blocks
    ////////////////////

    // Port names match the wires above one to one
    friscv_control   u_control   (.*);
    friscv_decoder   u_decoder   (.*);
    friscv_registers u_registers (.*);
    friscv_alu       u_alu       (.*);
    friscv_memfy     u_memfy     (.*);

endmodule

//--- processing/friscv_memfy.sv
// Word store unit on an AXI4-lite write channel, one store at a time
// wstrb is fixed to all ones, the write response is not checked
module friscv_memfy import friscv_pkg::*; (
    input  logic            aclk,
    input  logic            rst,
    input  logic            st_start,
    input  logic [XLEN-1:0] st_addr,
    input  logic [XLEN-1:0] st_data,
    output logic            st_done,
    output logic            dmem_awvalid,
    input  logic            dmem_awready,
    output logic [XLEN-1:0] dmem_awaddr,
    output logic            dmem_wvalid,
    input  logic            dmem_wready,
    output logic [XLEN-1:0] dmem_wdata,
    output logic [3:0]      dmem_wstrb,
    input  logic            dmem_bvalid,
    output logic            dmem_bready
);

    logic aw_last;
    logic w_last;

    // Channel done this cycle, or already done earlier
    assign aw_last = !dmem_awvalid || dmem_awready;
    assign w_last  = !dmem_wvalid || dmem_wready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            dmem_awvalid <= 1'b0;
            dmem_wvalid  <= 1'b0;
            dmem_bready  <= 1'b0;
            st_done      <= 1'b0;
        end else begin
            st_done <= 1'b0;
            if (st_start) begin
                dmem_awvalid <= 1'b1;
                dmem_wvalid  <= 1'b1;
            end else begin
                // AW and W drop their valid independently
                if (dmem_awready) dmem_awvalid <= 1'b0;
                if (dmem_wready) dmem_wvalid <= 1'b0;
                if ((dmem_awvalid || dmem_wvalid) && aw_last && w_last) begin
                    dmem_bready <= 1'b1;
                end
                if (dmem_bready && dmem_bvalid) begin
                    dmem_bready <= 1'b0;
                    st_done     <= 1'b1;
                end
            end
        end
    end

    // Payload held for the whole transfer
    always_ff @(posedge aclk) begin
        if (st_start) begin
            dmem_awaddr <= st_addr;
            dmem_wdata  <= st_data;
        end
    end

    assign dmem_wstrb = 4'hF;

endmodule

//--- processing/friscv_alu.sv
// Combinational ALU with branch comparator and next PC
// Misaligned jump targets are not checked
module friscv_alu import friscv_pkg::*; (
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_val,
    input  logic [XLEN-1:0] rs2_val,
    input  logic [XLEN-1:0] imm,
    input  alu_op_t         alu_op,
    input  logic            use_imm,
    input  br_op_t          br_op,
    input  opcode_t         opcode,
    output logic [XLEN-1:0] alu_result,
    output logic            branch_taken,
    output logic [XLEN-1:0] next_pc,
    output logic [XLEN-1:0] link_val
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] jalr_target;
    logic            cond;

    // AUIPC adds the immediate to the PC
    assign op_a = (opcode == AUIPC) ? pc : rs1_val;
    assign op_b = use_imm ? imm : rs2_val;

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << op_b[4:0];
            ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> op_b[4:0];
            ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    ////////////////////
    // Branches and jumps
    ////////////////////

    always_comb begin
        case (br_op)
            BR_EQ:   cond = (rs1_val == rs2_val);
            BR_NE:   cond = (rs1_val != rs2_val);
            BR_LT:   cond = ($signed(rs1_val) < $signed(rs2_val));
            BR_GE:   cond = ($signed(rs1_val) >= $signed(rs2_val));
            BR_LTU:  cond = (rs1_val < rs2_val);
            BR_GEU:  cond = (rs1_val >= rs2_val);
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = (opcode == BRANCH) && cond;
    assign jalr_target  = (rs1_val + imm) & ~32'h1;
    assign link_val     = pc + 32'd4;

    assign next_pc = (opcode == JALR)                  ? jalr_target :
                     (opcode == JAL || branch_taken)   ? pc + imm    :
                                                         link_val;

endmodule

//--- control/friscv_control.sv
// Fetch and execute sequencer, not pipelined, one fetch in flight
// ECALL, EBREAK and illegal words set a sticky status bit and halt
module friscv_control import friscv_pkg::*; (
    input  logic                  aclk,
    input  logic                  rst,
    // Instruction read channel
    output logic                  imem_arvalid,
    input  logic                  imem_arready,
    output logic [XLEN-1:0]       imem_araddr,
    input  logic                  imem_rvalid,
    output logic                  imem_rready,
    input  logic [ILEN-1:0]       imem_rdata,
    // Decoder
    output logic [ILEN-1:0]       instr,
    input  opcode_t               opcode,
    input  logic                  illegal,
    input  logic                  is_ecall,
    input  logic                  is_ebreak,
    input  logic [REG_ADDR_W-1:0] rd_addr,
    // ALU and register operands
    input  logic [XLEN-1:0]       alu_result,
    input  logic                  branch_taken,
    input  logic [XLEN-1:0]       next_pc,
    input  logic [XLEN-1:0]       link_val,
    input  logic [XLEN-1:0]       rs2_val,
    output logic [XLEN-1:0]       pc,
    // Register writeback
    output logic                  rd_wr,
    output logic [XLEN-1:0]       rd_wdata,
    // Store unit
    output logic                  st_start,
    output logic [XLEN-1:0]       st_addr,
    output logic [XLEN-1:0]       st_data,
    input  logic                  st_done,
    output logic [STATUS_W-1:0]   status
);

    typedef enum logic [2:0] {
        S_FETCH,
        S_WAIT,
        S_EXEC,
        S_STORE,
        S_HALT
    } state_t;

    state_t state;
    logic   trap;
    logic   jump;
    logic   writes_rd;

    assign trap      = illegal | is_ecall | is_ebreak;
    assign jump      = (opcode == JAL) || (opcode == JALR);
    assign writes_rd = (opcode == OP) || (opcode == OP_IMM) || (opcode == LUI) ||
                       (opcode == AUIPC) || jump;

    ////////////////////
    // Sequencer
    ////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            state        <= S_FETCH;
            imem_arvalid <= 1'b0;
            pc           <= BOOT_ADDR;
            status       <= '0;
        end else begin
            case (state)
                S_FETCH: begin
                    // arvalid comes up on the first cycle out of reset
                    if (imem_arvalid && imem_arready) begin
                        imem_arvalid <= 1'b0;
                        state        <= S_WAIT;
                    end else begin
                        imem_arvalid <= 1'b1;
                    end
                end
                S_WAIT: begin
                    if (imem_rvalid) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (trap) begin
                        status[ST_ILLEGAL] <= illegal;
                        status[ST_ECALL]   <= is_ecall & ~illegal;
                        status[ST_EBREAK]  <= is_ebreak & ~illegal;
                        state              <= S_HALT;
                    end else begin
                        pc <= (branch_taken || jump) ? next_pc : link_val;
                        if (opcode == STORE) begin
                            state <= S_STORE;
                        end else begin
                            imem_arvalid <= 1'b1;
                            state        <= S_FETCH;
                        end
                    end
                end
                S_STORE: begin
                    if (st_done) begin
                        imem_arvalid <= 1'b1;
                        state        <= S_FETCH;
                    end
                end
                default: begin
                    // Halted until reset
                    state <= S_HALT;
                end
            endcase
        end
    end

    // Instruction word, a payload register
    always_ff @(posedge aclk) begin
        if (state == S_WAIT && imem_rvalid) begin
            instr <= imem_rdata;
        end
    end

    assign imem_araddr = pc;
    assign imem_rready = (state == S_WAIT);

    ////////////////////
    // Writeback and store request
    ////////////////////

    assign rd_wr    = (state == S_EXEC) && !trap && writes_rd && (rd_addr != '0);
    assign rd_wdata = jump ? link_val : alu_result;

    assign st_start = (state == S_EXEC) && !trap && (opcode == STORE);
    assign st_addr  = alu_result;
    assign st_data  = rs2_val;

endmodule

//--- control/friscv_decoder.sv
// Combinational RV32I decoder for the kept subset
// Loads, FENCE, CSR access and sub-word stores decode as illegal
module friscv_decoder import friscv_pkg::*; (
    input  logic [ILEN-1:0]       instr,
    output opcode_t               opcode,
    output logic [REG_ADDR_W-1:0] rs1_addr,
    output logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [REG_ADDR_W-1:0] rd_addr,
    output logic [XLEN-1:0]       imm,
    output alu_op_t               alu_op,
    output logic                  use_imm,
    output br_op_t                br_op,
    output logic                  is_ecall,
    output logic                  is_ebreak,
    output logic                  illegal
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    // funct3 to ALU operation, alt selects SUB or SRA
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];
    assign opcode   = opcode_t'(instr[6:0]);
    assign br_op    = br_op_t'(funct3);

    always_comb begin
        imm       = {{20{instr[31]}}, instr[31:20]};
        alu_op    = ALU_ADD;
        use_imm   = 1'b1;
        is_ecall  = 1'b0;
        is_ebreak = 1'b0;
        illegal   = 1'b0;
        case (instr[6:0])
            OP: begin
                use_imm = 1'b0;
                alu_op  = arith_op(funct3, instr[30]);
                illegal = !(funct7 == 7'h00 ||
                            (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OP_IMM: begin
                alu_op = arith_op(funct3, funct3 == 3'b101 && instr[30]);
                // Shift amounts only use the low five bits
                if (funct3 == 3'b001) illegal = (funct7 != 7'h00);
                if (funct3 == 3'b101) illegal = (funct7 != 7'h00 && funct7 != 7'h20);
            end
            LUI: begin
                imm    = {instr[31:12], 12'b0};
                alu_op = ALU_PASS_B;
            end
            AUIPC: imm = {instr[31:12], 12'b0};
            JAL: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                        instr[30:21], 1'b0};
            JALR: illegal = (funct3 != 3'b000);
            BRANCH: begin
                imm     = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
                use_imm = 1'b0;
                illegal = (funct3 == 3'b010 || funct3 == 3'b011);
            end
            STORE: begin
                imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                illegal = (funct3 != 3'b010);
            end
            SYSTEM: begin
                is_ecall  = (instr == 32'h0000_0073);
                is_ebreak = (instr == 32'h0010_0073);
                illegal   = !(is_ecall || is_ebreak);
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

//--- src/friscv_registers.sv
// 32 integer registers, asynchronous read, write on the clock edge
// x0 ignores writes and so always reads zero
module friscv_registers import friscv_pkg::*; (
    input  logic                  aclk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [XLEN-1:0]       rs1_val,
    output logic [XLEN-1:0]       rs2_val,
    input  logic                  rd_wr,
    input  logic [REG_ADDR_W-1:0] rd_addr,
    input  logic [XLEN-1:0]       rd_wdata
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wr && rd_addr != '0) begin
            regs[rd_addr] <= rd_wdata;
        end
    end

    assign rs1_val = regs[rs1_addr];
    assign rs2_val = regs[rs2_addr];

endmodule

//--- common/friscv_pkg.sv
// Shared widths and encodings of the RV32I core
// Only the kept subset of the base ISA has an opcode here
package friscv_pkg;

    ////////////////////
    // Widths
    ////////////////////

    localparam int XLEN       = 32;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int STATUS_W   = 8;

    // First fetch address after reset
    localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0000;

    // Status bus bit positions, bits 2 and 4 to 7 stay zero
    localparam int ST_ECALL   = 0;
    localparam int ST_EBREAK  = 1;
    localparam int ST_ILLEGAL = 3;

    ////////////////////
    // Encodings
    ////////////////////

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        STORE  = 7'b0100011,
        SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    // Same values as the branch funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_op_t;

endpackage
